// File: Makefile
# Verilator build and run of the frame builder testbench

VERILATOR ?= verilator
TOP       ?= bpsi_tb
FLIST     ?= bpsi_framer.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	elif ! grep -q "sim passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bpsi_framer.f
verilog/bpsi_pkg.sv
verilog/readback_capture.sv
verilog/adc_capture.sv
verilog/sync_fifo.sv
verilog/frame_arbiter.sv
verilog/bpsi_framer_top.sv
verification/bpsi_tb.sv

// File: verification/bpsi_tb.sv
`timescale 1ns/1ns
`default_nettype none

module bpsi_tb import bpsi_pkg::*; ();

    localparam int TB_DECIM = 3;
    localparam int TB_BLOCK = 8;

    logic        clk_i;
    logic        rst_i;
    logic        rb_vld_i;
    logic        rb_last_i;
    rb_word_t    rb_data_i;
    logic        adc_en_i;
    logic        adc_vld_i;
    adc_sample_t adc_data_i;
    logic        tx_ack_i;
    logic        frame_start_o;
    frame_len_t  frame_len_o;
    tx_out_t     tx_o;

    // expected frames per channel with payload bytes only
    int          rb_len_q[$];
    tx_byte_t    rb_byte_q[$];
    int          adc_len_q[$];
    tx_byte_t    adc_byte_q[$];
    tx_byte_t    adc_part_q[$];
    logic [15:0] type_log[$];
    tx_byte_t    got[$];

    logic [31:0] rng = 32'haa9aa507;
    // separate stream for the acknowledge delay
    logic [31:0] ack_rng = 32'haa9aa507;
    int          dec_cnt = 0;
    int          blk_cnt = 0;
    int          exp_bytes = 0;
    int          cycles = 0;
    int          cur_len = 0;
    int          ack_wait = -1;
    bit          in_frame = 0;
    bit          hold_ack = 0;

    bpsi_framer_top #(
        .ADC_DECIM (TB_DECIM),
        .ADC_BLOCK (TB_BLOCK)
    ) dut0 (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .rb_vld_i      (rb_vld_i),
        .rb_last_i     (rb_last_i),
        .rb_data_i     (rb_data_i),
        .adc_en_i      (adc_en_i),
        .adc_vld_i     (adc_vld_i),
        .adc_data_i    (adc_data_i),
        .tx_ack_i      (tx_ack_i),
        .frame_start_o (frame_start_o),
        .frame_len_o   (frame_len_o),
        .tx_o          (tx_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic value_error(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus with model update
    //////////////////////////////////////////////////////////////////////

    task automatic send_burst(input int n);
        rb_word_t w;
        int       g;
        for (int i = 0; i < n; i++) begin
            rng = xorshift(rng);
            g = rng % 3;
            repeat (g) begin
                @(posedge clk_i);
                rb_vld_i  <= 1'b0;
                rb_last_i <= 1'b0;
            end
            rng = xorshift(rng);
            w = rng;
            @(posedge clk_i);
            rb_vld_i  <= 1'b1;
            rb_data_i <= w;
            rb_last_i <= (i == n - 1);
            // most significant byte first
            rb_byte_q.push_back(w[31:24]);
            rb_byte_q.push_back(w[23:16]);
            rb_byte_q.push_back(w[15:8]);
            rb_byte_q.push_back(w[7:0]);
        end
        @(posedge clk_i);
        rb_vld_i  <= 1'b0;
        rb_last_i <= 1'b0;
        rb_len_q.push_back(HDR_BYTES + 4 * n);
        exp_bytes += HDR_BYTES + 4 * n;
    endtask

    task automatic send_samples(input int n);
        adc_sample_t s;
        int          g;
        for (int i = 0; i < n; i++) begin
            rng = xorshift(rng);
            g = rng % 3;
            repeat (g) begin
                @(posedge clk_i);
                adc_vld_i <= 1'b0;
            end
            rng = xorshift(rng);
            s = rng[15:0];
            @(posedge clk_i);
            adc_vld_i  <= 1'b1;
            adc_data_i <= s;
            dec_cnt++;
            if (dec_cnt == TB_DECIM) begin
                dec_cnt = 0;
                // low byte first on the link
                adc_part_q.push_back(s[7:0]);
                adc_part_q.push_back(s[15:8]);
                blk_cnt++;
                if (blk_cnt == TB_BLOCK) begin
                    blk_cnt = 0;
                    while (adc_part_q.size() > 0) begin
                        adc_byte_q.push_back(adc_part_q.pop_front());
                    end
                    adc_len_q.push_back(HDR_BYTES + 2 * TB_BLOCK);
                    exp_bytes += HDR_BYTES + 2 * TB_BLOCK;
                end
            end
        end
        @(posedge clk_i);
        adc_vld_i <= 1'b0;
    endtask

    // all expected frames sent and acknowledged
    task automatic wait_idle();
        do begin
            @(posedge clk_i);
        end while (rb_len_q.size() != 0 || adc_len_q.size() != 0 || in_frame
                   || ack_wait != -1 || tx_ack_i);
    endtask

    //////////////////////////////////////////////////////////////////////
    // frame monitor, acknowledge and timeout
    //////////////////////////////////////////////////////////////////////

    task automatic check_frame();
        logic [15:0] tcode;
        int          exp_len;
        tx_byte_t    exp_b;
        tcode = {got[0], got[1]};
        type_log.push_back(tcode);
        if (tcode == READBACK_TYPE) begin
            assert (rb_len_q.size() > 0) else value_error("unexpected readback frame");
            exp_len = rb_len_q.pop_front();
        end else begin
            assert (tcode == RAWADC_TYPE) else value_error($sformatf("bad type %h", tcode));
            assert (adc_len_q.size() > 0) else value_error("unexpected adc frame");
            exp_len = adc_len_q.pop_front();
        end
        assert (cur_len == exp_len)
            else value_error($sformatf("frame_len %0d, expected %0d", cur_len, exp_len));
        for (int i = HDR_BYTES; i < exp_len; i++) begin
            exp_b = (tcode == READBACK_TYPE) ? rb_byte_q.pop_front() : adc_byte_q.pop_front();
            assert (got[i] == exp_b)
                else value_error($sformatf("byte %0d is %h, expected %h", i, got[i], exp_b));
        end
    endtask

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > 20 * exp_bytes + 2000) begin
            stop_with_error("timeout: frames did not finish within the cycle limit");
        end
        if (!rst_i) begin
            tx_ack_i <= 1'b0;
            if (frame_start_o) begin
                assert (!in_frame) else value_error("start pulse inside a frame");
                in_frame = 1;
                cur_len = frame_len_o;
                got.delete();
            end
            if (tx_o.byte_en) begin
                assert (in_frame) else value_error("byte_en high between frames");
                got.push_back(tx_o.data);
                if (got.size() == cur_len) begin
                    check_frame();
                    in_frame = 0;
                    ack_rng = xorshift(ack_rng);
                    ack_wait = hold_ack ? -2 : int'(ack_rng % 6);
                end
            end
            if (ack_wait == -2 && !hold_ack) begin
                ack_wait = 0;
            end
            if (ack_wait == 0) begin
                tx_ack_i <= 1'b1;
                ack_wait = -1;
            end else if (ack_wait > 0) begin
                ack_wait--;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst_i      = 1'b1;
        rb_vld_i   = 1'b0;
        rb_last_i  = 1'b0;
        rb_data_i  = '0;
        adc_en_i   = 1'b0;
        adc_vld_i  = 1'b0;
        adc_data_i = '0;
        tx_ack_i   = 1'b0;
        repeat (16) @(posedge clk_i);
        rst_i <= 1'b0;

        // readback bursts of random length
        repeat (3) begin
            rng = xorshift(rng);
            send_burst(1 + int'(rng % 40));
            wait_idle();
        end

        // adc blocks with random valid gaps
        @(posedge clk_i);
        adc_en_i <= 1'b1;
        send_samples(TB_DECIM * TB_BLOCK * 2);
        wait_idle();

        // both channels pending while an adc frame waits for its acknowledge
        hold_ack = 1;
        send_samples(TB_DECIM * TB_BLOCK);
        wait (type_log.size() > 0 && ack_wait == -2);
        rng = xorshift(rng);
        send_burst(1 + int'(rng % 40));
        send_samples(TB_DECIM * TB_BLOCK);
        repeat (3) @(posedge clk_i);
        hold_ack = 0;
        wait_idle();
        assert (type_log[$-1] == READBACK_TYPE && type_log[$] == RAWADC_TYPE)
            else value_error("frames after held acknowledge do not alternate");

        // partial block discarded when the adc is disabled
        send_samples(TB_DECIM * 4);
        @(posedge clk_i);
        adc_en_i <= 1'b0;
        dec_cnt = 0;
        blk_cnt = 0;
        adc_part_q.delete();
        repeat (3) @(posedge clk_i);
        adc_en_i <= 1'b1;
        send_samples(TB_DECIM * TB_BLOCK);
        wait_idle();

        rng = xorshift(rng);
        send_burst(1 + int'(rng % 40));
        wait_idle();
        repeat (10) @(posedge clk_i);

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/adc_capture.sv
`timescale 1ns/1ns
`default_nettype none

module adc_capture import bpsi_pkg::*; #(
    parameter int ADC_DECIM = DEF_ADC_DECIM,
    parameter int ADC_BLOCK = DEF_ADC_BLOCK
) (
    input  wire              clk_i,
    input  wire              rst_i,
    input  wire              adc_en_i,
    input  wire              adc_vld_i,
    input  wire adc_sample_t adc_data_i,
    input  wire              done_i,
    output logic             wr_en_o,
    output adc_sample_t      wr_data_o,
    output logic             flush_o,
    output logic             pend_o
);

    localparam int DEC_W = $clog2(ADC_DECIM + 1);
    localparam int BLK_W = $clog2(ADC_BLOCK + 1);
    // enough for every block the FIFO can hold plus one closing
    localparam int PND_W = $clog2(ADC_FIFO_DEPTH / ADC_BLOCK + 2);

    logic [DEC_W-1:0] dec_cnt;
    logic [BLK_W-1:0] blk_cnt;
    logic [PND_W-1:0] pend_cnt;
    logic             keep;
    logic             blk_end;

    assign keep    = adc_en_i && adc_vld_i && (dec_cnt == DEC_W'(ADC_DECIM - 1));
    assign blk_end = keep && (blk_cnt == BLK_W'(ADC_BLOCK - 1));

    //////////////////////////////////////////////////////////////////////
    // decimation and block counting
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i || !adc_en_i) begin
            dec_cnt <= '0;
        end else if (adc_vld_i) begin
            dec_cnt <= keep ? '0 : dec_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || !adc_en_i) begin
            blk_cnt <= '0;
        end else if (blk_end) begin
            blk_cnt <= '0;
        end else if (keep) begin
            blk_cnt <= blk_cnt + 1'b1;
        end
    end

    // closed blocks still waiting for the link
    always_ff @(posedge clk_i) begin
        if (rst_i || !adc_en_i) begin
            pend_cnt <= '0;
        end else if (blk_end && !done_i) begin
            pend_cnt <= pend_cnt + 1'b1;
        end else if (done_i && !blk_end && (pend_cnt != '0)) begin
            pend_cnt <= pend_cnt - 1'b1;
        end
    end

    assign wr_en_o   = keep;
    // low byte in the upper half so the serializer sends it first
    assign wr_data_o = {adc_data_i[7:0], adc_data_i[15:8]};
    assign flush_o   = !adc_en_i;
    assign pend_o    = (pend_cnt != '0);

endmodule

`default_nettype wire

// File: verilog/bpsi_framer_top.sv
`timescale 1ns/1ns
`default_nettype none

module bpsi_framer_top import bpsi_pkg::*; #(
    parameter int ADC_DECIM = DEF_ADC_DECIM,
    parameter int ADC_BLOCK = DEF_ADC_BLOCK
) (
    input  wire              clk_i,
    input  wire              rst_i,
    input  wire              rb_vld_i,
    input  wire              rb_last_i,
    input  wire rb_word_t    rb_data_i,
    input  wire              adc_en_i,
    input  wire              adc_vld_i,
    input  wire adc_sample_t adc_data_i,
    input  wire              tx_ack_i,
    output logic             frame_start_o,
    output frame_len_t       frame_len_o,
    output tx_out_t          tx_o
);

    rb_req_t     rb_req;
    logic        rb_done;
    logic        rb_rd_en;
    logic        rb_rd_vld;
    rb_word_t    rb_rd_data;
    logic        rb_empty;
    logic        adc_done;
    logic        adc_pend;
    logic        adc_flush;
    logic        adc_wr_en;
    adc_sample_t adc_wr_data;
    logic        adc_rd_en;
    logic        adc_rd_vld;
    adc_sample_t adc_rd_data;
    logic        adc_empty;

    //////////////////////////////////////////////////////////////////////
    // readback channel
    //////////////////////////////////////////////////////////////////////

    readback_capture u_rb_cap (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rb_vld_i  (rb_vld_i),
        .rb_last_i (rb_last_i),
        .done_i    (rb_done),
        .req_o     (rb_req)
    );

    sync_fifo #(
        .T     (rb_word_t),
        .DEPTH (RB_FIFO_DEPTH)
    ) u_rb_fifo (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .flush_i   (1'b0),
        .wr_en_i   (rb_vld_i),
        .wr_data_i (rb_data_i),
        .rd_en_i   (rb_rd_en),
        .rd_vld_o  (rb_rd_vld),
        .rd_data_o (rb_rd_data),
        .empty_o   (rb_empty),
        .full_o    ()
    );

    //////////////////////////////////////////////////////////////////////
    // adc channel
    //////////////////////////////////////////////////////////////////////

    adc_capture #(
        .ADC_DECIM (ADC_DECIM),
        .ADC_BLOCK (ADC_BLOCK)
    ) u_adc_cap (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .adc_en_i   (adc_en_i),
        .adc_vld_i  (adc_vld_i),
        .adc_data_i (adc_data_i),
        .done_i     (adc_done),
        .wr_en_o    (adc_wr_en),
        .wr_data_o  (adc_wr_data),
        .flush_o    (adc_flush),
        .pend_o     (adc_pend)
    );

    sync_fifo #(
        .T     (adc_sample_t),
        .DEPTH (ADC_FIFO_DEPTH)
    ) u_adc_fifo (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .flush_i   (adc_flush),
        .wr_en_i   (adc_wr_en),
        .wr_data_i (adc_wr_data),
        .rd_en_i   (adc_rd_en),
        .rd_vld_o  (adc_rd_vld),
        .rd_data_o (adc_rd_data),
        .empty_o   (adc_empty),
        .full_o    ()
    );

    //////////////////////////////////////////////////////////////////////
    // arbiter and serializer
    //////////////////////////////////////////////////////////////////////

    frame_arbiter #(
        .ADC_BLOCK (ADC_BLOCK)
    ) u_arb (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .rb_req_i      (rb_req),
        .adc_pend_i    (adc_pend),
        .rb_empty_i    (rb_empty),
        .rb_rd_vld_i   (rb_rd_vld),
        .rb_rd_data_i  (rb_rd_data),
        .adc_empty_i   (adc_empty),
        .adc_rd_vld_i  (adc_rd_vld),
        .adc_rd_data_i (adc_rd_data),
        .tx_ack_i      (tx_ack_i),
        .rb_done_o     (rb_done),
        .adc_done_o    (adc_done),
        .rb_rd_en_o    (rb_rd_en),
        .adc_rd_en_o   (adc_rd_en),
        .frame_start_o (frame_start_o),
        .frame_len_o   (frame_len_o),
        .tx_o          (tx_o)
    );

endmodule

`default_nettype wire

// File: verilog/bpsi_pkg.sv
`default_nettype none

package bpsi_pkg;

    //////////////////////////////////////////////////////////////////////
    // payload and link types
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] rb_word_t;
    typedef logic [15:0] adc_sample_t;
    typedef logic [7:0]  tx_byte_t;
    typedef logic [15:0] frame_len_t;
    typedef logic [10:0] rb_count_t;

    // one closed readback burst waiting for the link
    typedef struct packed {
        logic      pending;
        rb_count_t words;
    } rb_req_t;

    // byte stream towards the slave link
    typedef struct packed {
        logic     byte_en;
        tx_byte_t data;
    } tx_out_t;

    //////////////////////////////////////////////////////////////////////
    // frame constants
    //////////////////////////////////////////////////////////////////////

    // type codes, high byte goes out first
    localparam logic [15:0] READBACK_TYPE = 16'h1002;
    localparam logic [15:0] RAWADC_TYPE   = 16'h1004;

    // type code bytes ahead of the payload
    localparam int HDR_BYTES = 2;

    localparam int RB_FIFO_DEPTH  = 1024;
    localparam int ADC_FIFO_DEPTH = 1024;

    // hardware defaults, overridden at the top level
    localparam int DEF_ADC_DECIM = 100000;
    localparam int DEF_ADC_BLOCK = 512;

endpackage

`default_nettype wire

// File: verilog/frame_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module frame_arbiter import bpsi_pkg::*; #(
    parameter int ADC_BLOCK = DEF_ADC_BLOCK
) (
    input  wire              clk_i,
    input  wire              rst_i,
    input  wire rb_req_t     rb_req_i,
    input  wire              adc_pend_i,
    input  wire              rb_empty_i,
    input  wire              rb_rd_vld_i,
    input  wire rb_word_t    rb_rd_data_i,
    input  wire              adc_empty_i,
    input  wire              adc_rd_vld_i,
    input  wire adc_sample_t adc_rd_data_i,
    input  wire              tx_ack_i,
    output logic             rb_done_o,
    output logic             adc_done_o,
    output logic             rb_rd_en_o,
    output logic             adc_rd_en_o,
    output logic             frame_start_o,
    output frame_len_t       frame_len_o,
    output tx_out_t          tx_o
);

    localparam frame_len_t ADC_LEN = frame_len_t'(HDR_BYTES + 2 * ADC_BLOCK);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_TYPE_HI,
        ST_TYPE_LO,
        ST_PAYLOAD,
        ST_WAIT_ACK
    } state_t;

    state_t      state;
    logic        ptr;
    logic        sel;
    logic        any_req;
    logic        grant_adc;
    rb_count_t   unit_total;
    rb_count_t   unit_cnt;
    logic        rd_pend;
    rb_word_t    shreg;
    logic [2:0]  bytes_left;
    logic [15:0] type_code;
    logic        fifo_empty;
    logic        fifo_vld;
    logic        pop;
    logic        last_byte;

    // for ptr and sel 0 is readback and 1 is adc
    assign any_req    = rb_req_i.pending || adc_pend_i;
    assign grant_adc  = ptr ? adc_pend_i : !rb_req_i.pending;
    assign type_code  = sel ? RAWADC_TYPE : READBACK_TYPE;
    assign fifo_empty = sel ? adc_empty_i : rb_empty_i;
    assign fifo_vld   = sel ? adc_rd_vld_i : rb_rd_vld_i;

    //////////////////////////////////////////////////////////////////////
    // arbitration FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= ST_IDLE;
            ptr   <= 1'b0;
            sel   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (any_req) begin
                        sel   <= grant_adc;
                        state <= ST_START;
                    end
                end
                ST_START:   state <= ST_TYPE_HI;
                ST_TYPE_HI: state <= ST_TYPE_LO;
                ST_TYPE_LO: state <= ST_PAYLOAD;
                ST_PAYLOAD: begin
                    if (last_byte) begin
                        state <= ST_WAIT_ACK;
                    end
                end
                ST_WAIT_ACK: begin
                    // hand the next turn to the other channel
                    if (tx_ack_i) begin
                        ptr   <= !sel;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // frame size latched with the grant
    always_ff @(posedge clk_i) begin
        if ((state == ST_IDLE) && any_req) begin
            if (grant_adc) begin
                unit_total  <= rb_count_t'(ADC_BLOCK);
                frame_len_o <= ADC_LEN;
            end else begin
                unit_total  <= rb_req_i.words;
                frame_len_o <= frame_len_t'(HDR_BYTES) + frame_len_t'({rb_req_i.words, 2'b00});
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // payload fetch and byte shifter
    //////////////////////////////////////////////////////////////////////

    // fetch early so the next unit lands as the current one drains
    assign pop = (state inside {ST_TYPE_HI, ST_TYPE_LO, ST_PAYLOAD}) && !rd_pend
               && (bytes_left <= 3'd2) && (unit_cnt != unit_total) && !fifo_empty;
    assign rb_rd_en_o  = pop && !sel;
    assign adc_rd_en_o = pop && sel;

    assign last_byte = (state == ST_PAYLOAD) && (bytes_left == 3'd1) && !rd_pend
                     && (unit_cnt == unit_total);

    always_ff @(posedge clk_i) begin
        if (rst_i || (state == ST_IDLE)) begin
            unit_cnt <= '0;
        end else if (pop) begin
            unit_cnt <= unit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= pop;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bytes_left <= '0;
        end else if (fifo_vld) begin
            bytes_left <= sel ? 3'd2 : 3'd4;
        end else if ((state == ST_PAYLOAD) && (bytes_left != '0)) begin
            bytes_left <= bytes_left - 1'b1;
        end
    end

    // msb first with adc samples in the upper half
    always_ff @(posedge clk_i) begin
        if (fifo_vld) begin
            shreg <= sel ? {adc_rd_data_i, 16'h0000} : rb_rd_data_i;
        end else if ((state == ST_PAYLOAD) && (bytes_left != '0)) begin
            shreg <= {shreg[23:0], 8'h00};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // link outputs
    //////////////////////////////////////////////////////////////////////

    assign frame_start_o = (state == ST_START);
    assign rb_done_o     = (state == ST_WAIT_ACK) && tx_ack_i && !sel;
    assign adc_done_o    = (state == ST_WAIT_ACK) && tx_ack_i && sel;

    always_comb begin
        tx_o = '0;
        case (state)
            ST_TYPE_HI: tx_o = '{byte_en: 1'b1, data: type_code[15:8]};
            ST_TYPE_LO: tx_o = '{byte_en: 1'b1, data: type_code[7:0]};
            ST_PAYLOAD: tx_o = '{byte_en: (bytes_left != '0), data: shreg[31:24]};
            default:    tx_o = '0;
        endcase
    end

    // the adc must stay enabled while its block is on the link
    a_adc_block_held: assert property (
        @(posedge clk_i) disable iff (rst_i)
        ((state != ST_IDLE) && sel) |-> adc_pend_i
    );

    // readback data only returns for a request issued here
    a_rb_vld_owned: assert property (
        @(posedge clk_i) disable iff (rst_i) rb_rd_vld_i |-> $past(rb_rd_en_o));

endmodule

`default_nettype wire

// File: verilog/readback_capture.sv
`timescale 1ns/1ns
`default_nettype none

module readback_capture import bpsi_pkg::*; (
    input  wire     clk_i,
    input  wire     rst_i,
    input  wire     rb_vld_i,
    input  wire     rb_last_i,
    input  wire     done_i,
    output rb_req_t req_o
);

    rb_count_t word_cnt;
    logic      last_word;

    // last only counts together with a valid word
    assign last_word = rb_vld_i && rb_last_i;

    //////////////////////////////////////////////////////////////////////
    // burst length
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            word_cnt <= '0;
        end else if (last_word) begin
            word_cnt <= '0;
        end else if (rb_vld_i) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // frame request
    //////////////////////////////////////////////////////////////////////

    // held until the arbiter sees the link acknowledge
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            req_o <= '0;
        end else if (last_word) begin
            req_o.pending <= 1'b1;
            req_o.words   <= word_cnt + 1'b1;
        end else if (done_i) begin
            req_o.pending <= 1'b0;
        end
    end

    // a second burst may only close once the previous frame is acknowledged
    a_no_burst_overrun: assert property (
        @(posedge clk_i) disable iff (rst_i)
        last_word |-> (!req_o.pending || done_i)
    );

endmodule

`default_nettype wire

// File: verilog/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo import bpsi_pkg::*; #(
    parameter type T     = tx_byte_t,
    parameter int  DEPTH = 16
) (
    input  wire   clk_i,
    input  wire   rst_i,
    input  wire   flush_i,
    input  wire   wr_en_i,
    input  wire T wr_data_i,
    input  wire   rd_en_i,
    output logic  rd_vld_o,
    output T      rd_data_o,
    output logic  empty_o,
    output logic  full_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_wr;
    logic          do_rd;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty_o = (count == '0);
    assign full_o  = (count == CW'(DEPTH));
    assign do_wr   = wr_en_i && !full_o && !flush_i;
    assign do_rd   = rd_en_i && !empty_o && !flush_i;

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // pointers and occupancy, flush empties the buffer
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // standard read mode, data and valid one cycle after the request
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            rd_vld_o <= 1'b0;
        end else begin
            rd_vld_o <= do_rd;
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_rd) begin
            rd_data_o <= mem[rd_ptr];
        end
    end

    a_no_overflow: assert property (
        @(posedge clk_i) disable iff (rst_i) (wr_en_i && !flush_i) |-> !full_o);

    a_no_underflow: assert property (
        @(posedge clk_i) disable iff (rst_i) (rd_en_i && !flush_i) |-> !empty_o);

endmodule

`default_nettype wire
